// File: src/ifetch_pkg.sv
`default_nettype none

// Shared definitions for the instruction fetch front end
package ifetch_pkg;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // Byte address on the instruction bus; fetches only ever use word-aligned values
  typedef logic [31:0] addr_t;

  // One 32-bit instruction word as returned on the R channel
  typedef logic [31:0] word_t;

  // Adapter FSM states
  // TRANSPARENT passes transaction requests straight to the A channel
  // REGISTERED replays a captured address until the bus grants it
  typedef enum logic
  {
    TRANSPARENT = 1'b0,
    REGISTERED  = 1'b1
  } obi_state_e;

  //////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////

  // First fetch address after reset
  localparam addr_t BOOT_ADDR = 32'h0000_0080;

  // Number of fetch buffer slots
  // This also bounds the OBI transactions that can be in flight
  localparam int BUF_DEPTH = 4;

  // Slot pointer width, enough to index BUF_DEPTH slots
  localparam int BUF_PTR_W = 2;

endpackage

`default_nettype wire

// File: src/obi_instr_if.sv
`timescale 1ns/1ps
`default_nettype none

// Read-only OBI bus between the fetch adapter and instruction memory
interface obi_instr_if;
  import ifetch_pkg::*;

  // A channel
  logic  req;
  logic  gnt;
  addr_t addr;

  // R channel, one rvalid cycle per granted request, never back-pressured
  logic  rvalid;
  word_t rdata;
  logic  err;

  // Bus master side, held by the fetch adapter
  modport master
  (
    output req,
    output addr,
    input  gnt,
    input  rvalid,
    input  rdata,
    input  err
  );

  // Memory side of the bus
  modport slave
  (
    input  req,
    input  addr,
    output gnt,
    output rvalid,
    output rdata,
    output err
  );

endinterface

`default_nettype wire

// File: src/fetch_alloc_if.sv
`timescale 1ns/1ps
`default_nettype none

// Slot allocation and flush path from the address generator to the fetch buffer
interface fetch_alloc_if;
  import ifetch_pkg::*;

  // A slot is taken on a cycle with alloc_valid and alloc_ready both high
  logic  alloc_valid;
  logic  alloc_ready;
  addr_t alloc_addr;

  // One-cycle pulse that retires the whole old fetch path
  logic  flush;

  // Address generator side
  modport gen
  (
    output alloc_valid,
    output alloc_addr,
    output flush,
    input  alloc_ready
  );

  // Fetch buffer side
  modport buffer
  (
    input  alloc_valid,
    input  alloc_addr,
    input  flush,
    output alloc_ready
  );

endinterface

`default_nettype wire

// File: src/instr_obi_adapter.sv
`timescale 1ns/1ps
`default_nettype none

// Turns trans_* requests into OBI A-channel transfers that stay stable until granted
// R-channel responses are forwarded unchanged on resp_*
module instr_obi_adapter
(
  input  logic               clk,
  input  logic               rst_n,

  // Transaction request side
  input  logic               trans_valid_i,
  output logic               trans_ready_o,
  input  ifetch_pkg::addr_t  trans_addr_i,

  // Transaction response side, the consumer is always receptive
  output logic               resp_valid_o,
  output ifetch_pkg::word_t  resp_rdata_o,
  output logic               resp_err_o,

  // Instruction bus
  obi_instr_if.master        obi
);
  import ifetch_pkg::*;

  obi_state_e state_q;
  obi_state_e next_state;

  // Address replayed on the bus while a request waits for its grant
  addr_t      obi_addr_q;

  //////////////////////////////////////////////////
  // R channel
  //////////////////////////////////////////////////

  // Responses pass straight through
  assign resp_valid_o = obi.rvalid;
  assign resp_rdata_o = obi.rdata;
  assign resp_err_o   = obi.err;

  //////////////////////////////////////////////////
  // A channel FSM
  //////////////////////////////////////////////////

  always_comb
  begin
    next_state = state_q;
    case (state_q)
      // Requests go to the bus as they come; a missing grant means we must start holding
      TRANSPARENT:
      begin
        if (obi.req && !obi.gnt)
        begin
          next_state = REGISTERED;
        end
      end
      // Bus sees the captured address until the grant arrives
      REGISTERED:
      begin
        if (obi.gnt)
        begin
          next_state = TRANSPARENT;
        end
      end
      default:
      begin
        next_state = TRANSPARENT;
      end
    endcase
  end

  // Request and address muxing onto the bus
  always_comb
  begin
    if (state_q == TRANSPARENT)
    begin
      obi.req  = trans_valid_i;
      obi.addr = trans_addr_i;
    end
    else
    begin
      // A request once raised is never withdrawn
      obi.req  = 1'b1;
      obi.addr = obi_addr_q;
    end
  end

  // New transactions are taken only while nothing is waiting for a grant
  assign trans_ready_o = (state_q == TRANSPARENT);

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= TRANSPARENT;
    end
    else
    begin
      state_q <= next_state;
    end
  end

  // Capture the ungranted address on the way into REGISTERED
  always_ff @(posedge clk)
  begin
    if ((state_q == TRANSPARENT) && (next_state == REGISTERED))
    begin
      obi_addr_q <= trans_addr_i;
    end
  end

endmodule

`default_nettype wire

// File: src/fetch_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Produces the fetch address stream, sequential from BOOT_ADDR and redirected by branches
// A fetch is only offered while the buffer has a free slot for it
module fetch_addr_gen
(
  input  logic               clk,
  input  logic               rst_n,

  // Redirect from the execute side
  input  logic               branch_i,
  input  ifetch_pkg::addr_t  branch_addr_i,

  // Transaction request to the bus adapter
  output logic               trans_valid_o,
  input  logic               trans_ready_i,
  output ifetch_pkg::addr_t  trans_addr_o,

  // Slot allocation and flush towards the fetch buffer
  fetch_alloc_if.gen         alloc
);
  import ifetch_pkg::*;

  // Address of the next word to fetch
  addr_t next_addr_q;

  // Goes high on the first edge after reset is released and keeps requests off before that
  logic  started_q;

  // Transaction accepted by the adapter and slot taken in the buffer, both this cycle
  logic  handover;

  //////////////////////////////////////////////////
  // Request generation
  //////////////////////////////////////////////////

  // Buffer credit is taken from alloc_ready
  // Nothing is offered in a branch cycle so no old-path fetch is allocated after the flush
  assign trans_valid_o = started_q && alloc.alloc_ready && !branch_i;
  assign trans_addr_o  = next_addr_q;

  assign handover = trans_valid_o && trans_ready_i;

  // The slot is allocated on the very cycle the adapter takes the transaction
  assign alloc.alloc_valid = handover;
  assign alloc.alloc_addr  = next_addr_q;

  // Everything already allocated belongs to the old path when a branch comes in
  assign alloc.flush = branch_i;

  //////////////////////////////////////////////////
  // Address register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      started_q   <= 1'b0;
      next_addr_q <= BOOT_ADDR;
    end
    else
    begin
      started_q <= 1'b1;
      if (branch_i)
      begin
        // Redirect wins over any sequential step
        next_addr_q <= branch_addr_i;
      end
      else if (handover)
      begin
        next_addr_q <= next_addr_q + 32'd4;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// In-order queue of fetches from allocation until decode consumes them
// Slots are taken at hand-over, filled on rvalid and retired from the head
module fetch_buffer
(
  input  logic               clk,
  input  logic               rst_n,

  // Slot allocation and flush from the address generator
  fetch_alloc_if.buffer      alloc,

  // Responses from the bus adapter
  input  logic               resp_valid_i,
  input  ifetch_pkg::word_t  resp_rdata_i,
  input  logic               resp_err_i,

  // Decode side
  output logic               instr_valid_o,
  input  logic               instr_ready_i,
  output ifetch_pkg::addr_t  instr_addr_o,
  output ifetch_pkg::word_t  instr_rdata_o,
  output logic               instr_err_o
);
  import ifetch_pkg::*;

  // Slot storage
  addr_t addr_q     [BUF_DEPTH];
  word_t rdata_q    [BUF_DEPTH];
  logic  err_q      [BUF_DEPTH];
  logic  killed_q   [BUF_DEPTH];
  logic  returned_q [BUF_DEPTH];

  // Allocate, response and head pointers walk the slots in the same order
  logic [BUF_PTR_W-1:0] alloc_ptr_q;
  logic [BUF_PTR_W-1:0] resp_ptr_q;
  logic [BUF_PTR_W-1:0] head_ptr_q;

  // Slots in use, from 0 up to BUF_DEPTH
  logic [BUF_PTR_W:0]   count_q;

  logic do_alloc;
  logic head_done;
  logic do_pop;

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  assign alloc.alloc_ready = (count_q < BUF_DEPTH[BUF_PTR_W:0]);
  assign do_alloc          = alloc.alloc_valid && alloc.alloc_ready;

  // Head slot holds a response, live or killed
  assign head_done = (count_q != '0) && returned_q[head_ptr_q];

  // Killed heads drain on their own, live heads wait for decode
  assign do_pop = head_done && (killed_q[head_ptr_q] || instr_ready_i);

  // Output comes straight from registered head state
  assign instr_valid_o = head_done && !killed_q[head_ptr_q];
  assign instr_addr_o  = addr_q[head_ptr_q];
  assign instr_rdata_o = rdata_q[head_ptr_q];
  assign instr_err_o   = err_q[head_ptr_q];

  //////////////////////////////////////////////////
  // Slot payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (do_alloc)
    begin
      addr_q[alloc_ptr_q] <= alloc.alloc_addr;
    end
    if (resp_valid_i)
    begin
      rdata_q[resp_ptr_q] <= resp_rdata_i;
      err_q[resp_ptr_q]   <= resp_err_i;
    end
  end

  //////////////////////////////////////////////////
  // Slot state and pointers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      alloc_ptr_q <= '0;
      resp_ptr_q  <= '0;
      head_ptr_q  <= '0;
      count_q     <= '0;
      for (int i = 0; i < BUF_DEPTH; i++)
      begin
        killed_q[i]   <= 1'b0;
        returned_q[i] <= 1'b0;
      end
    end
    else
    begin
      // A flush kills every slot; returned ones drain at once and the others on rvalid
      if (alloc.flush)
      begin
        for (int i = 0; i < BUF_DEPTH; i++)
        begin
          killed_q[i] <= 1'b1;
        end
      end
      // A new slot starts live and empty (never in a flush cycle)
      if (do_alloc)
      begin
        killed_q[alloc_ptr_q]   <= 1'b0;
        returned_q[alloc_ptr_q] <= 1'b0;
        alloc_ptr_q             <= alloc_ptr_q + 1'b1;
      end
      // Responses come back in order, so they fill the oldest outstanding slot
      if (resp_valid_i)
      begin
        returned_q[resp_ptr_q] <= 1'b1;
        resp_ptr_q             <= resp_ptr_q + 1'b1;
      end
      if (do_pop)
      begin
        head_ptr_q <= head_ptr_q + 1'b1;
      end
      if (do_alloc && !do_pop)
      begin
        count_q <= count_q + 1'b1;
      end
      else if (!do_alloc && do_pop)
      begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/ifetch_top.sv
`timescale 1ns/1ps
`default_nettype none

// Instruction fetch front end
// Joins the address generator, the OBI adapter and the fetch buffer
module ifetch_top
(
  input  logic               clk,
  input  logic               rst_n,

  // Branch redirect
  input  logic               branch_i,
  input  ifetch_pkg::addr_t  branch_addr_i,

  // Decode side
  output logic               instr_valid_o,
  input  logic               instr_ready_i,
  output ifetch_pkg::addr_t  instr_addr_o,
  output ifetch_pkg::word_t  instr_rdata_o,
  output logic               instr_err_o,

  // OBI instruction bus
  output logic               obi_req_o,
  input  logic               obi_gnt_i,
  output ifetch_pkg::addr_t  obi_addr_o,
  input  logic               obi_rvalid_i,
  input  ifetch_pkg::word_t  obi_rdata_i,
  input  logic               obi_err_i
);
  import ifetch_pkg::*;

  // Generator to adapter
  logic  trans_valid;
  logic  trans_ready;
  addr_t trans_addr;

  // Adapter to buffer
  logic  resp_valid;
  word_t resp_rdata;
  logic  resp_err;

  obi_instr_if   obi_bus ();
  fetch_alloc_if alloc_bus ();

  //////////////////////////////////////////////////
  // Bus pins
  //////////////////////////////////////////////////

  assign obi_req_o      = obi_bus.req;
  assign obi_addr_o     = obi_bus.addr;
  assign obi_bus.gnt    = obi_gnt_i;
  assign obi_bus.rvalid = obi_rvalid_i;
  assign obi_bus.rdata  = obi_rdata_i;
  assign obi_bus.err    = obi_err_i;

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////

  fetch_addr_gen addr_gen0
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .trans_valid_o (trans_valid),
    .trans_ready_i (trans_ready),
    .trans_addr_o  (trans_addr),
    .alloc         (alloc_bus.gen)
  );

  instr_obi_adapter adapter0
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans_valid_i (trans_valid),
    .trans_ready_o (trans_ready),
    .trans_addr_i  (trans_addr),
    .resp_valid_o  (resp_valid),
    .resp_rdata_o  (resp_rdata),
    .resp_err_o    (resp_err),
    .obi           (obi_bus.master)
  );

  fetch_buffer buffer0
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .alloc         (alloc_bus.buffer),
    .resp_valid_i  (resp_valid),
    .resp_rdata_i  (resp_rdata),
    .resp_err_i    (resp_err),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_addr_o  (instr_addr_o),
    .instr_rdata_o (instr_rdata_o),
    .instr_err_o   (instr_err_o)
  );

endmodule

`default_nettype wire

// File: tests/obi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

// OBI instruction memory for the testbench
// Grants after a random wait of 0 to 3 cycles and answers in order 1 to 4 cycles later
// It also watches the master side of the bus and raises fault_o on a protocol violation
module obi_mem_model
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_i,
  output logic               gnt_o,
  input  ifetch_pkg::addr_t  addr_i,
  output logic               rvalid_o,
  output ifetch_pkg::word_t  rdata_o,
  output logic               err_o,
  output logic               fault_o
);
  import ifetch_pkg::*;

  // Granted addresses waiting for their response, with the cycle each one is due
  addr_t pend_addr [$];
  int    pend_due  [$];

  int    cyc_cnt;
  int    grant_wait;
  logic  held;
  addr_t held_addr;
  addr_t resp_addr;

  // Memory contents, a fixed scramble of the word address
  function automatic word_t mem_word(input addr_t addr);
    mem_word = {addr[15:0], addr[31:16]} ^ (addr * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
  endfunction

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      gnt_o      <= 1'b0;
      rvalid_o   <= 1'b0;
      rdata_o    <= '0;
      err_o      <= 1'b0;
      fault_o    <= 1'b0;
      pend_addr.delete();
      pend_due.delete();
      cyc_cnt    = 0;
      grant_wait = 0;
      held       = 1'b0;
      held_addr  = '0;
    end
    else
    begin
      cyc_cnt = cyc_cnt + 1;
      // A request left waiting last cycle must still be there with the same address
      if (held && (!req_i || (addr_i != held_addr)))
      begin
        $display("Protocol violation at %0t: request dropped or address changed before grant",
                 $time);
        fault_o <= 1'b1;
      end
      held      = req_i && !gnt_o;
      held_addr = addr_i;
      // A-channel transfer completes here
      if (req_i && gnt_o)
      begin
        pend_addr.push_back(addr_i);
        pend_due.push_back(cyc_cnt + $urandom_range(0, 3));
        grant_wait = $urandom_range(0, 3);
        if (pend_addr.size() > BUF_DEPTH)
        begin
          $display("Protocol violation at %0t: %0d transactions outstanding, limit is %0d",
                   $time, pend_addr.size(), BUF_DEPTH);
          fault_o <= 1'b1;
        end
      end
      else if (req_i && (grant_wait != 0))
      begin
        grant_wait = grant_wait - 1;
      end
      gnt_o <= (grant_wait == 0);
      // Oldest pending read answers once its delay has run out
      rvalid_o <= 1'b0;
      if ((pend_addr.size() != 0) && (cyc_cnt >= pend_due[0]))
      begin
        resp_addr = pend_addr.pop_front();
        void'(pend_due.pop_front());
        rvalid_o  <= 1'b1;
        rdata_o   <= mem_word(resp_addr);
        err_o     <= (resp_addr[31:28] == 4'hF);
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_ifetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ifetch;
  import ifetch_pkg::*;

  // Stimulus length, then the watchdog limit with room to drain the last fetches
  localparam int RUN_CYCLES     = 3000;
  localparam int TIMEOUT_CYCLES = RUN_CYCLES + 1000;
  localparam int MIN_INSTR      = 500;

  logic  clk = 1'b0;
  logic  rst_n;
  logic  branch_i;
  addr_t branch_addr_i;
  logic  instr_valid_o;
  logic  instr_ready_i;
  addr_t instr_addr_o;
  word_t instr_rdata_o;
  logic  instr_err_o;
  logic  obi_req;
  logic  obi_gnt;
  addr_t obi_addr;
  logic  obi_rvalid;
  word_t obi_rdata;
  logic  obi_err;
  logic  mem_fault;

  // Reference model state, the address decode should see next
  addr_t exp_addr   = BOOT_ADDR;
  int    consumed   = 0;
  int    cycle_cnt  = 0;
  int    stim_cnt   = 0;
  int    stall_left = 0;

  ifetch_top dut0
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_addr_o  (instr_addr_o),
    .instr_rdata_o (instr_rdata_o),
    .instr_err_o   (instr_err_o),
    .obi_req_o     (obi_req),
    .obi_gnt_i     (obi_gnt),
    .obi_addr_o    (obi_addr),
    .obi_rvalid_i  (obi_rvalid),
    .obi_rdata_i   (obi_rdata),
    .obi_err_i     (obi_err)
  );

  obi_mem_model mem0
  (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (obi_req),
    .gnt_o    (obi_gnt),
    .addr_i   (obi_addr),
    .rvalid_o (obi_rvalid),
    .rdata_o  (obi_rdata),
    .err_o    (obi_err),
    .fault_o  (mem_fault)
  );

  // Same scramble the memory holds, so every word can be predicted from its address
  function automatic word_t expected_word(input addr_t addr);
    expected_word = {addr[15:0], addr[31:16]} ^ (addr * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
  endfunction

  // Word-aligned branch target, roughly one in ten lands in the error region
  function automatic addr_t branch_target();
    addr_t target;
    target      = $urandom();
    target[1:0] = 2'b00;
    if ($urandom_range(0, 9) == 0)
    begin
      target[31:28] = 4'hF;
    end
    else
    begin
      target[31:28] = 4'h0;
    end
    branch_target = target;
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_addr(input string what, input addr_t act, input addr_t exp);
    if (act !== exp)
    begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, act, exp);
      $display("ERRORS FOUND");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic check_word(input string what, input word_t act, input word_t exp);
    if (act !== exp)
    begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, act, exp);
      $display("ERRORS FOUND");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_bit(input string what, input logic act, input logic exp);
    if (act !== exp)
    begin
      $display("Error at %0t: %s is %b, expected %b", $time, what, act, exp);
      $display("ERRORS FOUND");
      $fatal(1, "flag mismatch");
    end
  endtask

  always #4 clk = ~clk;

  //////////////////////////////////////////////////
  // Monitor and reference model
  //////////////////////////////////////////////////

  always @(posedge clk)
  begin : monitor
    addr_t next_exp;
    cycle_cnt <= cycle_cnt + 1;
    next_exp  = exp_addr;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: only %0d instructions consumed within %0d cycles",
               consumed, TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end
    else if (mem_fault)
    begin
      $display("The memory model saw a bus protocol violation");
      $display("ERRORS FOUND");
      $fatal(1, "bus protocol violation");
    end
    else if (!rst_n)
    begin
      check_bit("instr_valid_o in reset", instr_valid_o, 1'b0);
      check_bit("obi_req_o in reset", obi_req, 1'b0);
    end
    else
    begin
      // A consumption in the branch cycle itself still belongs to the old path
      if (instr_valid_o && instr_ready_i)
      begin
        check_addr("instr_addr_o", instr_addr_o, exp_addr);
        check_word("instr_rdata_o", instr_rdata_o, expected_word(exp_addr));
        check_bit("instr_err_o", instr_err_o, exp_addr[31:28] == 4'hF);
        consumed <= consumed + 1;
        next_exp = exp_addr + 32'd4;
      end
      if (branch_i)
      begin
        next_exp = branch_addr_i;
      end
      exp_addr <= next_exp;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial
  begin
    void'($urandom(14));
    rst_n         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    instr_ready_i = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    // Keep going past the planned length until enough instructions got through
    while ((stim_cnt < RUN_CYCLES) || (consumed < MIN_INSTR))
    begin
      @(posedge clk);
      stim_cnt = stim_cnt + 1;
      // Occasional long stall lets the buffer fill and the credit run out
      if (stall_left != 0)
      begin
        stall_left    = stall_left - 1;
        instr_ready_i <= 1'b0;
      end
      else if ($urandom_range(0, 199) == 0)
      begin
        stall_left    = 30;
        instr_ready_i <= 1'b0;
      end
      else
      begin
        instr_ready_i <= ($urandom_range(0, 99) >= 30);
      end
      if ($urandom_range(0, 39) == 0)
      begin
        branch_i      <= 1'b1;
        branch_addr_i <= branch_target();
      end
      else
      begin
        branch_i <= 1'b0;
      end
    end
    // The last edge has settled here, with its checks done and any bus fault visible
    @(negedge clk);
    if (mem_fault)
    begin
      $display("The memory model saw a bus protocol violation");
      $display("ERRORS FOUND");
      $fatal(1, "bus protocol violation");
    end
    else
    begin
      $display("Consumed %0d instructions in %0d cycles", consumed, cycle_cnt);
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
src/ifetch_pkg.sv
src/obi_instr_if.sv
src/fetch_alloc_if.sv
src/instr_obi_adapter.sv
src/fetch_addr_gen.sv
src/fetch_buffer.sv
src/ifetch_top.sv
tests/obi_mem_model.sv
tests/tb_ifetch.sv

// File: run.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_ifetch -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_ifetch)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
